// File: list.f
+incdir+source
source/gfx_pkg.sv
source/gfx_test_pattern.sv
source/fb_bank.sv
source/vga_scanout.sv
source/gfx_demo.sv
testbench/gfx_demo_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing -Wno-fatal -f list.f --top-module gfx_demo_tb \
  -Mdir "$OBJ" -o gfx_demo_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/gfx_demo_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/fb_bank.sv
`timescale 1ns/10ps

`include "gfx_settings.svh"

module fb_bank #(
  parameter int BANK = 0
) (
  input  logic                clk,
  input  logic                rst_n,

  // pixel writes from the generator, shared by both banks
  input  gfx_pkg::fb_write_t  wr,
  input  logic                wr_valid,
  output logic                wr_ready,

  // reads from scan-out, data comes back one cycle later
  input  gfx_pkg::fb_read_t   rd,
  input  logic                rd_en,
  output gfx_pkg::rgb_t       rd_data
);
  localparam int X_DEPTH   = 1 << `GFX_X_BITS;
  localparam int ROW_DEPTH = 1 << (`GFX_Y_BITS - 1);
  localparam logic PARITY  = 1'(BANK);

  gfx_pkg::rgb_t mem [0:X_DEPTH-1][0:ROW_DEPTH-1];

  logic wr_hit;

  // one access per cycle, a read wins over a write
  assign wr_ready = !rd_en;

  // only rows of this bank's parity land here
  assign wr_hit = wr_valid && wr_ready && (wr.y[0] == PARITY);

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr.x][wr.y[`GFX_Y_BITS-1:1]] <= wr.color;
    end
  end

  // registered read port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd.x][rd.row];
    end
  end

endmodule

// File: source/gfx_demo.sv
`timescale 1ns/10ps

`include "gfx_settings.svh"

module gfx_demo (
  input  logic                        clk,
  input  logic                        rst_n,

  output logic [`GFX_COLOR_BITS-1:0]  vga_red,
  output logic [`GFX_COLOR_BITS-1:0]  vga_grn,
  output logic [`GFX_COLOR_BITS-1:0]  vga_blu,
  output logic                        vga_hsync,
  output logic                        vga_vsync
);
  // generator to banks
  gfx_pkg::fb_write_t wr;
  logic               wr_valid;
  logic               wr_ready0;
  logic               wr_ready1;
  logic               frame_done;

  // scan-out to banks
  gfx_pkg::fb_read_t  rd;
  logic               rd_en0;
  logic               rd_en1;
  gfx_pkg::rgb_t      rd_data0;
  gfx_pkg::rgb_t      rd_data1;

  gfx_test_pattern u_gfx_test_pattern (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .wr_valid   (wr_valid),
    .wr_ready0  (wr_ready0),
    .wr_ready1  (wr_ready1),
    .frame_done (frame_done)
  );

  // even rows
  fb_bank #(
    .BANK (0)
  ) u_fb_bank0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready0),
    .rd       (rd),
    .rd_en    (rd_en0),
    .rd_data  (rd_data0)
  );

  // odd rows
  fb_bank #(
    .BANK (1)
  ) u_fb_bank1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready1),
    .rd       (rd),
    .rd_en    (rd_en1),
    .rd_data  (rd_data1)
  );

  vga_scanout u_vga_scanout (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_done (frame_done),
    .rd         (rd),
    .rd_en0     (rd_en0),
    .rd_en1     (rd_en1),
    .rd_data0   (rd_data0),
    .rd_data1   (rd_data1),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

endmodule

// File: source/gfx_pkg.sv
`include "gfx_settings.svh"

package gfx_pkg;

  // one pixel, 4 bits per channel
  typedef struct packed {
    logic [`GFX_COLOR_BITS-1:0] red;
    logic [`GFX_COLOR_BITS-1:0] grn;
    logic [`GFX_COLOR_BITS-1:0] blu;
  } rgb_t;

  // one pixel write from the generator
  // y is the full frame row, its lsb selects the bank
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x;
    logic [`GFX_Y_BITS-1:0] y;
    rgb_t                   color;
  } fb_write_t;

  // one read request into a bank
  // row is the row index within that bank (frame row / 2)
  typedef struct packed {
    logic [`GFX_X_BITS-1:0]   x;
    logic [`GFX_Y_BITS-2:0]   row;
  } fb_read_t;

  // scan-out waits for a complete frame before it starts
  typedef enum logic [0:0] {
    SCAN_WAIT,
    SCAN_RUN
  } scan_state_t;

endpackage

// File: source/gfx_settings.svh
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// tiny video mode so that simulation covers whole frames

// horizontal timing in clk cycles
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT 2
`define GFX_H_SYNC 3
`define GFX_H_BACK 3

// vertical timing in lines
`define GFX_V_VISIBLE 8
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 1

// bits per color channel
`define GFX_COLOR_BITS 4

// framebuffer coordinate widths
`define GFX_X_BITS 4
`define GFX_Y_BITS 3

// cycles between the first finished frame and the start of scan-out
`define GFX_START_DELAY 8

`endif

// File: source/gfx_test_pattern.sv
`timescale 1ns/10ps

`include "gfx_settings.svh"

module gfx_test_pattern (
  input  logic                clk,
  input  logic                rst_n,

  output gfx_pkg::fb_write_t  wr,
  output logic                wr_valid,
  input  logic                wr_ready0,
  input  logic                wr_ready1,

  output logic                frame_done
);
  localparam int X_BITS     = `GFX_X_BITS;
  localparam int Y_BITS     = `GFX_Y_BITS;
  localparam int COLOR_BITS = `GFX_COLOR_BITS;

  localparam logic [X_BITS-1:0] X_LAST = X_BITS'(`GFX_H_VISIBLE - 1);
  localparam logic [Y_BITS-1:0] Y_LAST = Y_BITS'(`GFX_V_VISIBLE - 1);

  logic [X_BITS-1:0]     x;
  logic [Y_BITS-1:0]     y;
  logic [COLOR_BITS-1:0] frame;
  logic                  wr_ready;
  logic                  accept;
  logic                  last_pixel;

  // the bank that owns this row decides the handshake
  assign wr_ready   = y[0] ? wr_ready1 : wr_ready0;
  assign accept     = wr_valid && wr_ready;
  assign last_pixel = (x == X_LAST) && (y == Y_LAST);

  // x, y and frame only move on accept, so wr holds under back-pressure
  assign wr.x         = x;
  assign wr.y         = y;
  assign wr.color.red = COLOR_BITS'(x);
  assign wr.color.grn = COLOR_BITS'(y) + frame;
  assign wr.color.blu = COLOR_BITS'(x) ^ frame;

  assign frame_done = accept && last_pixel;

  // offer pixels from the first cycle after reset on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= 1'b1;
    end
  end

  // raster walk, one step per accepted write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x     <= '0;
      y     <= '0;
      frame <= '0;
    end else if (accept) begin
      if (x == X_LAST) begin
        x <= '0;
        if (y == Y_LAST) begin
          y     <= '0;
          frame <= frame + 1'b1;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// File: source/vga_scanout.sv
`timescale 1ns/10ps

`include "gfx_settings.svh"

module vga_scanout (
  input  logic                        clk,
  input  logic                        rst_n,

  // pulse from the generator at the end of each drawn frame
  input  logic                        frame_done,

  // read requests to both banks, one shared address
  output gfx_pkg::fb_read_t           rd,
  output logic                        rd_en0,
  output logic                        rd_en1,
  input  gfx_pkg::rgb_t               rd_data0,
  input  gfx_pkg::rgb_t               rd_data1,

  output logic [`GFX_COLOR_BITS-1:0]  vga_red,
  output logic [`GFX_COLOR_BITS-1:0]  vga_grn,
  output logic [`GFX_COLOR_BITS-1:0]  vga_blu,
  output logic                        vga_hsync,
  output logic                        vga_vsync
);
  localparam int X_BITS = `GFX_X_BITS;
  localparam int Y_BITS = `GFX_Y_BITS;

  localparam int H_TOTAL = `GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int V_TOTAL = `GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;
  localparam int H_BITS  = $clog2(H_TOTAL);
  localparam int V_BITS  = $clog2(V_TOTAL);

  localparam logic [H_BITS-1:0] H_LAST = H_BITS'(H_TOTAL - 1);
  localparam logic [H_BITS-1:0] H_VIS  = H_BITS'(`GFX_H_VISIBLE);
  localparam logic [H_BITS-1:0] H_SYNC_BEG = H_BITS'(`GFX_H_VISIBLE + `GFX_H_FRONT);
  localparam logic [H_BITS-1:0] H_SYNC_END =
    H_BITS'(`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC);

  localparam logic [V_BITS-1:0] V_LAST = V_BITS'(V_TOTAL - 1);
  localparam logic [V_BITS-1:0] V_VIS  = V_BITS'(`GFX_V_VISIBLE);
  localparam logic [V_BITS-1:0] V_SYNC_BEG = V_BITS'(`GFX_V_VISIBLE + `GFX_V_FRONT);
  localparam logic [V_BITS-1:0] V_SYNC_END =
    V_BITS'(`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC);

  localparam int START_BITS = $clog2(`GFX_START_DELAY);
  localparam logic [START_BITS-1:0] START_LAST = START_BITS'(`GFX_START_DELAY - 1);

  gfx_pkg::scan_state_t  state;
  logic                  armed;
  logic [START_BITS-1:0] start_cnt;
  logic                  run;

  logic [H_BITS-1:0]     h;
  logic [V_BITS-1:0]     v;

  logic                  visible;
  logic                  hsync_n;
  logic                  vsync_n;

  logic                  vis_q;
  logic                  odd_q;
  logic                  hsync_q;
  logic                  vsync_q;
  gfx_pkg::rgb_t         pix;

  // start enable, counts a few cycles once the first frame is complete
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= gfx_pkg::SCAN_WAIT;
      armed     <= 1'b0;
      start_cnt <= '0;
    end else if (state == gfx_pkg::SCAN_WAIT) begin
      if (frame_done) begin
        armed <= 1'b1;
      end
      if (armed) begin
        start_cnt <= start_cnt + 1'b1;
        if (start_cnt == START_LAST) begin
          state <= gfx_pkg::SCAN_RUN;
        end
      end
    end
  end

  assign run = (state == gfx_pkg::SCAN_RUN);

  // position counters, held at 0,0 until running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h <= '0;
      v <= '0;
    end else if (run) begin
      if (h == H_LAST) begin
        h <= '0;
        v <= (v == V_LAST) ? '0 : v + 1'b1;
      end else begin
        h <= h + 1'b1;
      end
    end
  end

  assign visible = run && (h < H_VIS) && (v < V_VIS);
  assign hsync_n = !(run && (h >= H_SYNC_BEG) && (h < H_SYNC_END));
  assign vsync_n = !(run && (v >= V_SYNC_BEG) && (v < V_SYNC_END));

  // only the bank holding this row is read
  assign rd.x   = h[X_BITS-1:0];
  assign rd.row = v[Y_BITS-1:1];
  assign rd_en0 = visible && !v[0];
  assign rd_en1 = visible && v[0];

  // align control with the read latency of the banks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vis_q   <= 1'b0;
      odd_q   <= 1'b0;
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
    end else begin
      vis_q   <= visible;
      odd_q   <= v[0];
      hsync_q <= hsync_n;
      vsync_q <= vsync_n;
    end
  end

  // merge the two banks into one stream, black outside the visible area
  assign pix = odd_q ? rd_data1 : rd_data0;

  assign vga_red   = vis_q ? pix.red : '0;
  assign vga_grn   = vis_q ? pix.grn : '0;
  assign vga_blu   = vis_q ? pix.blu : '0;
  assign vga_hsync = hsync_q;
  assign vga_vsync = vsync_q;

endmodule

// File: testbench/gfx_demo_tb.sv
`timescale 1ns/10ps

`include "gfx_settings.svh"

module gfx_demo_tb;
  localparam int CB         = `GFX_COLOR_BITS;
  localparam int H_VIS      = `GFX_H_VISIBLE;
  localparam int H_SYNC_BEG = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_BEG + `GFX_H_SYNC;
  localparam int H_TOTAL    = H_SYNC_END + `GFX_H_BACK;
  localparam int V_VIS      = `GFX_V_VISIBLE;
  localparam int V_SYNC_BEG = `GFX_V_VISIBLE + `GFX_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_BEG + `GFX_V_SYNC;
  localparam int V_TOTAL    = V_SYNC_END + `GFX_V_BACK;

  localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
  localparam int FRAME_PIXELS   = H_VIS * V_VIS;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * FRAME_CYCLES + 200;
  localparam int START_DELAY    = `GFX_START_DELAY;
  localparam int PREDICT_FRAMES = 5;

  typedef logic [CB-1:0] chan_t;

  logic clk;
  logic rst_n;
  chan_t vga_red;
  chan_t vga_grn;
  chan_t vga_blu;
  logic vga_hsync;
  logic vga_vsync;

  // last sampled outputs and the position they belong to
  gfx_pkg::rgb_t cur_col;
  logic cur_hs;
  logic cur_vs;
  int pos_h;
  int pos_v;
  int pos_d;

  // frame value each visible pixel is read with, per displayed frame
  chan_t read_frame [0:PREDICT_FRAMES-1][0:H_VIS-1][0:V_VIS-1];

  int rgb_errors = 0;
  int bit_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;

  gfx_demo u_gfx_demo (
    .clk       (clk),
    .rst_n     (rst_n),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // test pattern: red is x, green is y plus frame, blue is x xor frame
  function automatic gfx_pkg::rgb_t pattern_color(input chan_t x, input chan_t y,
                                                  input chan_t frame);
    gfx_pkg::rgb_t c;
    c.red = x;
    c.grn = y + frame;
    c.blu = x ^ frame;
    return c;
  endfunction

  // replays generator writes against scan-out reads from the first frame_done on
  // frame 0 is complete there and the generator continues with frame 1
  task automatic predict_frames();
    chan_t mem [0:H_VIS-1][0:V_VIS-1];
    int gx;
    int gy;
    chan_t gf;
    int c;
    int h;
    int v;
    logic reading;
    for (int x = 0; x < H_VIS; x++) begin
      for (int y = 0; y < V_VIS; y++) begin
        mem[x][y] = '0;
      end
    end
    gx = 0;
    gy = 0;
    gf = 1;
    for (int k = 1; k <= START_DELAY + PREDICT_FRAMES * FRAME_CYCLES; k++) begin
      // scan position of the cycle ending at edge k, negative while scan-out waits
      c = k - START_DELAY - 1;
      reading = 1'b0;
      h = 0;
      v = 0;
      if (c >= 0) begin
        h = c % H_TOTAL;
        v = (c / H_TOTAL) % V_TOTAL;
        reading = (h < H_VIS) && (v < V_VIS);
      end
      if (reading) begin
        read_frame[c / FRAME_CYCLES][h][v] = mem[h][v];
      end
      // a read of the bank that holds the generator's row stalls the generator
      if (!(reading && (v % 2 == gy % 2))) begin
        mem[gx][gy] = gf;
        if (gx == H_VIS - 1) begin
          gx = 0;
          if (gy == V_VIS - 1) begin
            gy = 0;
            gf++;
          end else begin
            gy++;
          end
        end else begin
          gx++;
        end
      end
    end
  endtask

  task automatic compare_rgb(input string test_name, input gfx_pkg::rgb_t expected,
                             input gfx_pkg::rgb_t actual);
    if (actual !== expected) begin
      rgb_errors++;
      $display("error %s: expected %03h actual %03h", test_name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string test_name, input logic expected,
                             input logic actual);
    if (actual !== expected) begin
      bit_errors++;
      $display("error %s: expected %b actual %b", test_name, expected, actual);
    end
  endtask

  task automatic sample_outputs();
    @(posedge clk);
    cur_col = {vga_red, vga_grn, vga_blu};
    cur_hs  = vga_hsync;
    cur_vs  = vga_vsync;
  endtask

  task automatic next_cycle();
    pos_h = (pos_h == H_TOTAL - 1) ? 0 : pos_h + 1;
    if (pos_h == 0) begin
      pos_v = (pos_v == V_TOTAL - 1) ? 0 : pos_v + 1;
      if (pos_v == 0) begin
        pos_d++;
      end
    end
    sample_outputs();
  endtask

  task automatic test_idle_after_reset();
    gfx_pkg::rgb_t col_q[$];
    logic hs_q[$];
    logic vs_q[$];
    int idle_len;
    cur_hs = 1'b1;
    while (cur_hs !== 1'b0) begin
      sample_outputs();
      col_q.push_back(cur_col);
      hs_q.push_back(cur_hs);
      vs_q.push_back(cur_vs);
    end
    // the first hsync low is h = 18 of line 0, everything before line 0 is idle
    idle_len = col_q.size() - (H_SYNC_BEG + 1);
    if (idle_len < FRAME_PIXELS) begin
      other_errors++;
      $display("error idle_after_reset: scan-out started after %0d cycles, before a frame",
               idle_len);
    end
    for (int i = 0; i < idle_len; i++) begin
      compare_rgb("idle_after_reset color", '0, col_q[i]);
      compare_bit("idle_after_reset hsync", 1'b1, hs_q[i]);
      compare_bit("idle_after_reset vsync", 1'b1, vs_q[i]);
    end
  endtask

  // the first vsync falling edge marks h = 0 of line 9
  task automatic find_vsync_start();
    logic prev_vs;
    prev_vs = cur_vs;
    sample_outputs();
    while (!(prev_vs === 1'b1 && cur_vs === 1'b0)) begin
      prev_vs = cur_vs;
      sample_outputs();
    end
    pos_h = 0;
    pos_v = V_SYNC_BEG;
    pos_d = 0;
  endtask

  task automatic test_sync_timing();
    logic exp_hs;
    logic exp_vs;
    for (int n = 0; n < FRAME_CYCLES; n++) begin
      next_cycle();
      exp_hs = !(pos_h >= H_SYNC_BEG && pos_h < H_SYNC_END);
      exp_vs = !(pos_v >= V_SYNC_BEG && pos_v < V_SYNC_END);
      compare_bit($sformatf("sync_timing hsync (%0d,%0d)", pos_h, pos_v), exp_hs, cur_hs);
      compare_bit($sformatf("sync_timing vsync (%0d,%0d)", pos_h, pos_v), exp_vs, cur_vs);
    end
  endtask

  task automatic test_blanking();
    for (int n = 0; n < FRAME_CYCLES; n++) begin
      next_cycle();
      if (pos_h >= H_VIS || pos_v >= V_VIS) begin
        compare_rgb($sformatf("blanking (%0d,%0d)", pos_h, pos_v), '0, cur_col);
      end
    end
  endtask

  // a lost or repeated write shifts the colors and the frame values of a row
  task automatic test_pixel_content();
    gfx_pkg::rgb_t exp_col;
    for (int n = 0; n < 2 * FRAME_CYCLES; n++) begin
      next_cycle();
      if (pos_h < H_VIS && pos_v < V_VIS) begin
        exp_col = pattern_color(chan_t'(pos_h), chan_t'(pos_v),
                                read_frame[pos_d][pos_h][pos_v]);
        compare_rgb($sformatf("pixel_content frame %0d (%0d,%0d)", pos_d, pos_h, pos_v),
                    exp_col, cur_col);
      end
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    cur_col = '0;
    cur_hs = 1'b1;
    cur_vs = 1'b1;
    pos_h = 0;
    pos_v = 0;
    pos_d = 0;
    predict_frames();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    test_idle_after_reset();
    find_vsync_start();
    test_sync_timing();
    test_blanking();
    test_pixel_content();

    $display("errors: %0d color, %0d sync, %0d other", rgb_errors, bit_errors,
             other_errors);
    if (rgb_errors + bit_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
